//--- include/rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// integer register and data path width
`define RV_XLEN 64

// architectural registers, x0 included
`define RV_NREGS 32

// width of rs1, rs2 and rd fields
`define RV_REG_AW 5

`endif

//--- logic/rv_pkg.sv
`include "rv_cfg.svh"

package rv_pkg;

	// major opcodes, instr[6:0]
	typedef enum logic [6:0] {
		OP        = 7'b0110011,
		OP_IMM    = 7'b0010011,
		OP_32     = 7'b0111011,
		OP_IMM_32 = 7'b0011011,
		LUI       = 7'b0110111
	} opcode_e;

	// operations the alu can perform
	typedef enum logic [3:0] {
		ADD    = 4'd0,
		SUB    = 4'd1,
		SLL    = 4'd2,
		SLT    = 4'd3,
		SLTU   = 4'd4,
		XOR    = 4'd5,
		SRL    = 4'd6,
		SRA    = 4'd7,
		OR     = 4'd8,
		AND    = 4'd9,
		MUL    = 4'd10,
		// second operand straight through, for lui
		PASS_B = 4'd11
	} alu_op_e;

	// one decoded instruction
	typedef struct packed {
		alu_op_e                op;
		logic [`RV_REG_AW-1:0]  rd;
		logic [`RV_REG_AW-1:0]  rs1;
		logic [`RV_REG_AW-1:0]  rs2;
		logic [`RV_XLEN-1:0]    imm;
		logic                   use_imm;
		logic                   word;
		logic                   writes;
		logic                   illegal;
	} dec_t;

	// result leaving on the writeback port
	typedef struct packed {
		logic [`RV_REG_AW-1:0]  rd;
		logic [`RV_XLEN-1:0]    value;
		logic                   illegal;
	} wb_t;

endpackage

//--- logic/rv_decoder.sv
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_decoder (
	input  logic [31:0]   instr,
	output rv_pkg::dec_t  dec
);
	import rv_pkg::*;

	opcode_e             opcode;
	logic [2:0]          funct3;
	logic [6:0]          funct7;
	logic [`RV_XLEN-1:0] imm_i;
	logic [`RV_XLEN-1:0] imm_u;

	assign opcode = opcode_e'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	// sign extended I and U immediates
	assign imm_i = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
	assign imm_u = {{(`RV_XLEN-32){instr[31]}}, instr[31:12], 12'b0};

	always_comb begin
		dec         = '0;
		dec.op      = ADD;
		dec.rd      = instr[11:7];
		dec.rs1     = instr[19:15];
		dec.rs2     = instr[24:20];
		dec.imm     = imm_i;
		dec.illegal = 1'b1;
		case (opcode)
			OP: begin
				dec.writes = 1'b1;
				if (funct7 == 7'b0000000) begin
					dec.illegal = 1'b0;
					case (funct3)
						3'b000:  dec.op = ADD;
						3'b001:  dec.op = SLL;
						3'b010:  dec.op = SLT;
						3'b011:  dec.op = SLTU;
						3'b100:  dec.op = XOR;
						3'b101:  dec.op = SRL;
						3'b110:  dec.op = OR;
						default: dec.op = AND;
					endcase
				end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
					dec.op      = SUB;
					dec.illegal = 1'b0;
				end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
					dec.op      = SRA;
					dec.illegal = 1'b0;
				end else if (funct7 == 7'b0000001 && funct3 == 3'b000) begin
					dec.op      = MUL;
					dec.illegal = 1'b0;
				end else begin
					// mulh, div, rem and unknown funct7
					dec.writes = 1'b0;
				end
			end
			OP_IMM: begin
				dec.writes  = 1'b1;
				dec.use_imm = 1'b1;
				dec.illegal = 1'b0;
				case (funct3)
					3'b000: dec.op = ADD;
					3'b010: dec.op = SLT;
					3'b011: dec.op = SLTU;
					3'b100: dec.op = XOR;
					3'b110: dec.op = OR;
					3'b111: dec.op = AND;
					3'b001: begin
						dec.op = SLL;
						// 6 bit shamt, upper funct6 must be zero
						if (instr[31:26] != 6'b000000) begin
							dec.illegal = 1'b1;
							dec.writes  = 1'b0;
						end
					end
					default: begin
						if (instr[31:26] == 6'b000000) begin
							dec.op = SRL;
						end else if (instr[31:26] == 6'b010000) begin
							dec.op = SRA;
						end else begin
							dec.illegal = 1'b1;
							dec.writes  = 1'b0;
						end
					end
				endcase
			end
			OP_32: begin
				dec.word   = 1'b1;
				dec.writes = 1'b1;
				if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
					dec.op      = ADD;
					dec.illegal = 1'b0;
				end else if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
					dec.op      = SUB;
					dec.illegal = 1'b0;
				end else begin
					dec.writes = 1'b0;
				end
			end
			OP_IMM_32: begin
				dec.word    = 1'b1;
				dec.use_imm = 1'b1;
				dec.writes  = 1'b1;
				// only addiw, so every word shift amount is rejected
				if (funct3 == 3'b000) begin
					dec.op      = ADD;
					dec.illegal = 1'b0;
				end else begin
					dec.writes = 1'b0;
				end
			end
			LUI: begin
				dec.op      = PASS_B;
				dec.imm     = imm_u;
				dec.rs1     = '0;
				dec.rs2     = '0;
				dec.use_imm = 1'b1;
				dec.writes  = 1'b1;
				dec.illegal = 1'b0;
			end
			default: begin
				dec.writes = 1'b0;
			end
		endcase
	end

	// every reject path has to drop the register write
	a_no_illegal_write: assert final (!(dec.illegal && dec.writes));

endmodule

//--- logic/rv_regfile.sv
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_regfile (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic [`RV_REG_AW-1:0] rs1_addr,
	input  logic [`RV_REG_AW-1:0] rs2_addr,
	output logic [`RV_XLEN-1:0]   rs1_data,
	output logic [`RV_XLEN-1:0]   rs2_data,
	input  logic                  wr_en,
	input  logic [`RV_REG_AW-1:0] wr_addr,
	input  logic [`RV_XLEN-1:0]   wr_data
);

	// x1 to x31, x0 has no storage
	logic [`RV_XLEN-1:0] regs [1:`RV_NREGS-1];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < `RV_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// reads see the array directly, so a write shows up next cycle
	assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

//--- logic/rv_alu.sv
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_alu (
	input  rv_pkg::alu_op_e     op,
	input  logic [`RV_XLEN-1:0] a,
	input  logic [`RV_XLEN-1:0] b,
	input  logic                word,
	output logic [`RV_XLEN-1:0] result
);
	import rv_pkg::*;

	logic [5:0]          shamt;
	logic [`RV_XLEN-1:0] srl_src;
	logic [`RV_XLEN-1:0] sra_src;
	logic [`RV_XLEN-1:0] res;

	// word forms shift by 5 bits only
	assign shamt = word ? {1'b0, b[4:0]} : b[5:0];

	// low word extended so right shifts bring in the proper fill
	assign srl_src = word ? {{(`RV_XLEN-32){1'b0}}, a[31:0]} : a;
	assign sra_src = word ? {{(`RV_XLEN-32){a[31]}}, a[31:0]} : a;

	always_comb begin
		case (op)
			ADD:    res = a + b;
			SUB:    res = a - b;
			SLL:    res = a << shamt;
			SLT:    res = {{(`RV_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			SLTU:   res = {{(`RV_XLEN-1){1'b0}}, a < b};
			XOR:    res = a ^ b;
			SRL:    res = srl_src >> shamt;
			SRA:    res = $signed(sra_src) >>> shamt;
			OR:     res = a | b;
			AND:    res = a & b;
			// low half of the product
			MUL:    res = a * b;
			PASS_B: res = b;
			default: res = '0;
		endcase
	end

	// 32 bit result, sign extended
	assign result = word ? {{(`RV_XLEN-32){res[31]}}, res[31:0]} : res;

endmodule

//--- logic/rv_pipe_ctrl.sv
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_pipe_ctrl (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  in_valid,
	output logic                  in_ready,
	input  rv_pkg::dec_t          dec,
	output logic [`RV_REG_AW-1:0] rs1_addr,
	output logic [`RV_REG_AW-1:0] rs2_addr,
	input  logic [`RV_XLEN-1:0]   rs1_data,
	input  logic [`RV_XLEN-1:0]   rs2_data,
	output rv_pkg::alu_op_e       alu_op,
	output logic [`RV_XLEN-1:0]   alu_a,
	output logic [`RV_XLEN-1:0]   alu_b,
	output logic                  alu_word,
	input  logic [`RV_XLEN-1:0]   alu_result,
	output logic                  wr_en,
	output logic [`RV_REG_AW-1:0] wr_addr,
	output logic [`RV_XLEN-1:0]   wr_data,
	output logic                  out_valid,
	input  logic                  out_ready,
	output rv_pkg::wb_t           out_wb
);
	import rv_pkg::*;

	// stage A: decoded instruction and its operands
	logic                a_valid;
	dec_t                a_dec;
	logic [`RV_XLEN-1:0] a_op1;
	logic [`RV_XLEN-1:0] a_op2;

	// stage B: finished result
	logic                b_valid;
	wb_t                 b_wb;

	logic                a_load;
	logic                b_load;
	logic                a_move;
	logic                fwd1;
	logic                fwd2;
	logic [`RV_XLEN-1:0] op1_next;
	logic [`RV_XLEN-1:0] op2_next;

	assign b_load   = ~b_valid | out_ready;
	assign a_move   = a_valid & b_load;
	assign a_load   = ~a_valid | b_load;
	assign in_ready = a_load;

	assign rs1_addr = dec.rs1;
	assign rs2_addr = dec.rs2;

	// register write on the edge stage A hands over to B
	assign wr_en   = a_move & a_dec.writes & ~a_dec.illegal & (a_dec.rd != '0);
	assign wr_addr = a_dec.rd;
	assign wr_data = alu_result;

	// the leaving result is not in the register file yet
	assign fwd1 = wr_en & (dec.rs1 == a_dec.rd);
	assign fwd2 = wr_en & (dec.rs2 == a_dec.rd);

	assign op1_next = fwd1 ? alu_result : rs1_data;
	assign op2_next = dec.use_imm ? dec.imm : (fwd2 ? alu_result : rs2_data);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			a_valid <= 1'b0;
			b_valid <= 1'b0;
		end else begin
			if (a_load) begin
				a_valid <= in_valid;
			end
			if (b_load) begin
				b_valid <= a_valid;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (a_load && in_valid) begin
			a_dec <= dec;
			a_op1 <= op1_next;
			a_op2 <= op2_next;
		end
		if (a_move) begin
			b_wb.rd      <= a_dec.rd;
			b_wb.value   <= a_dec.illegal ? '0 : alu_result;
			b_wb.illegal <= a_dec.illegal;
		end
	end

	assign alu_op   = a_dec.op;
	assign alu_a    = a_op1;
	assign alu_b    = a_op2;
	assign alu_word = a_dec.word;

	assign out_valid = b_valid;
	assign out_wb    = b_wb;

	// stalled output must hold its result
	a_out_stable: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_wb));

	// never x0, and the written value shows up on the port next cycle
	a_write_matches_wb: assert property (@(posedge clk) disable iff (!arst_n)
		wr_en |-> (wr_addr != '0) ##1
		(out_valid && out_wb.rd == $past(wr_addr) && out_wb.value == $past(wr_data)));

endmodule

//--- logic/rv_exec_unit.sv
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_exec_unit (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        in_valid,
	output logic        in_ready,
	input  logic [31:0] in_instr,
	output logic        out_valid,
	input  logic        out_ready,
	output rv_pkg::wb_t out_wb
);
	import rv_pkg::*;

	dec_t                  dec;
	logic [`RV_REG_AW-1:0] rs1_addr;
	logic [`RV_REG_AW-1:0] rs2_addr;
	logic [`RV_XLEN-1:0]   rs1_data;
	logic [`RV_XLEN-1:0]   rs2_data;
	alu_op_e               alu_op;
	logic [`RV_XLEN-1:0]   alu_a;
	logic [`RV_XLEN-1:0]   alu_b;
	logic                  alu_word;
	logic [`RV_XLEN-1:0]   alu_result;
	logic                  wr_en;
	logic [`RV_REG_AW-1:0] wr_addr;
	logic [`RV_XLEN-1:0]   wr_data;

	rv_decoder rv_decoder_inst (
		.instr (in_instr),
		.dec   (dec)
	);

	rv_regfile rv_regfile_inst (
		.clk      (clk),
		.arst_n   (arst_n),
		.rs1_addr (rs1_addr),
		.rs2_addr (rs2_addr),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data)
	);

	rv_alu rv_alu_inst (
		.op     (alu_op),
		.a      (alu_a),
		.b      (alu_b),
		.word   (alu_word),
		.result (alu_result)
	);

	rv_pipe_ctrl rv_pipe_ctrl_inst (
		.clk        (clk),
		.arst_n     (arst_n),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.dec        (dec),
		.rs1_addr   (rs1_addr),
		.rs2_addr   (rs2_addr),
		.rs1_data   (rs1_data),
		.rs2_data   (rs2_data),
		.alu_op     (alu_op),
		.alu_a      (alu_a),
		.alu_b      (alu_b),
		.alu_word   (alu_word),
		.alu_result (alu_result),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_wb     (out_wb)
	);

endmodule

//--- testbench/tb_clkgen.sv
`timescale 1ns/1ns

module tb_clkgen (
	output logic clk,
	output logic arst_n
);

	// 40 ns period
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// reset held over the first two rising edges, released off the edge
	initial begin
		arst_n = 1'b0;
		repeat (2) @(posedge clk);
		#5;
		arst_n = 1'b1;
	end

endmodule

//--- testbench/rv_exec_tb.sv
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_exec_tb;
	import rv_pkg::*;

	localparam int MAX_TESTS = 64;

	logic        clk;
	logic        arst_n;
	logic        in_valid;
	logic        in_ready;
	logic [31:0] in_instr;
	logic        out_valid;
	logic        out_ready;
	wb_t         out_wb;

	// four words per test: instruction, rd, value, illegal
	logic [63:0] stim [0:4*MAX_TESTS-1];
	logic [15:0] lfsr;
	logic        in_fire;
	logic        r0;
	logic        r1;
	int          n_tests;
	int          sent;
	int          recv;
	int          cycles;
	int          limit;

	tb_clkgen tb_clkgen_inst (.clk(clk), .arst_n(arst_n));

	rv_exec_unit rv_exec_unit_inst (.*);

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic draw_bit(output logic b);
		lfsr = lfsr_next(lfsr);
		b = lfsr[0];
	endtask

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_writeback(input int idx);
		wb_t   exp;
		string msg;
		exp.rd      = stim[4*idx+1][`RV_REG_AW-1:0];
		exp.value   = stim[4*idx+2][`RV_XLEN-1:0];
		exp.illegal = stim[4*idx+3][0];
		msg = {$sformatf("Mismatch in test %0d (instr %h):", idx, stim[4*idx][31:0]),
			$sformatf(" expected rd %0d value %h illegal %0b,",
				exp.rd, exp.value, exp.illegal),
			$sformatf(" actual rd %0d value %h illegal %0b",
				out_wb.rd, out_wb.value, out_wb.illegal)};
		assert (out_wb === exp) else fail_run(msg);
	endtask

	initial begin
		in_valid  = 1'b0;
		in_instr  = '0;
		out_ready = 1'b0;
		in_fire   = 1'b0;
		lfsr      = 16'd38685;
		sent      = 0;
		recv      = 0;
		cycles    = 0;
		// slots past the file end get an upper word no instruction line has
		for (int i = 0; i < 4*MAX_TESTS; i++) begin
			stim[i] = {32'hffff_ffff, 32'(i)};
		end
		$readmemh("testbench/rv_exec_stim.txt", stim);
		n_tests = 0;
		while (n_tests < MAX_TESTS && stim[4*n_tests][63:32] == '0) begin
			n_tests++;
		end
		assert (n_tests > 0) else fail_run("no test lines read from the stimulus file");
		limit = 4 * n_tests + 50;

		@(posedge arst_n);
		@(posedge clk);
		#5;
		assert (out_valid === 1'b0 && in_ready === 1'b1)
			else fail_run("pipeline is not empty after reset");

		while (recv < n_tests) begin
			@(posedge clk);
			#5;
			if (in_fire) begin
				sent++;
			end
			// a new choice only once the held instruction has gone
			if (!in_valid || in_fire) begin
				draw_bit(r0);
				draw_bit(r1);
				in_valid = (sent < n_tests) && (r0 || r1);
				if (in_valid) begin
					in_instr = stim[4*sent][31:0];
				end
			end
			draw_bit(r0);
			draw_bit(r1);
			out_ready = r0 || r1;
			cycles++;
			assert (cycles <= limit) else fail_run($sformatf(
				"timeout after %0d cycles, only %0d of %0d writebacks arrived",
				cycles, recv, n_tests));
			// sample just ahead of the next edge
			#30;
			in_fire = in_valid && in_ready;
			assert (sent > 0 || out_valid === 1'b0)
				else fail_run("out_valid went high before any instruction was accepted");
			if (out_valid && out_ready) begin
				check_writeback(recv);
				recv++;
			end
		end

		// nothing may follow the last writeback
		repeat (3) begin
			@(posedge clk);
			#5;
			in_valid  = 1'b0;
			out_ready = 1'b1;
			#30;
			assert (out_valid === 1'b0)
				else fail_run("extra writeback after the last expected one");
		end
		assert (sent == n_tests) else fail_run("not every instruction was accepted");

		$display("Everything OK");
		$finish;
	end

endmodule

//--- compile.f
+incdir+include
logic/rv_pkg.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_pipe_ctrl.sv
logic/rv_exec_unit.sv
testbench/tb_clkgen.sv
testbench/rv_exec_tb.sv

//--- Bender.yml
package:
  name: rv_exec_unit

sources:
  - include_dirs:
      - include
    files:
      - logic/rv_pkg.sv
      - logic/rv_decoder.sv
      - logic/rv_regfile.sv
      - logic/rv_alu.sv
      - logic/rv_pipe_ctrl.sv
      - logic/rv_exec_unit.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_clkgen.sv
      - testbench/rv_exec_tb.sv

//--- testbench/rv_exec_stim.txt
// columns: instruction word, expected rd, expected value, expected illegal flag
// registers start at zero, results follow RV64IM semantics
00500093 01 0000000000000005 0
FFD00113 02 FFFFFFFFFFFFFFFD 0
002081B3 03 0000000000000002 0
40208233 04 0000000000000008 0
001122B3 05 0000000000000001 0
00113333 06 0000000000000000 0
FFE12393 07 0000000000000001 0
FFF0B413 08 0000000000000001 0
0F00C493 09 00000000000000F5 0
0044E533 0A 00000000000000FD 0
002575B3 0B 00000000000000FD 0
7FF17613 0C 00000000000007FD 0
F0006693 0D FFFFFFFFFFFFFF00 0
02809713 0E 0000050000000000 0
03C15793 0F 000000000000000F 0
40115813 10 FFFFFFFFFFFFFFFE 0
004098B3 11 0000000000000500 0
0046D933 12 00FFFFFFFFFFFFFF 0
4046D9B3 13 FFFFFFFFFFFFFFFF 0
7FFFFA37 14 000000007FFFF000 0
7FFA0A93 15 000000007FFFF7FF 0
015A8B3B 16 FFFFFFFFFFFFEFFE 0
41600BBB 17 0000000000001002 0
00168C1B 18 FFFFFFFFFFFFFF01 0
02D10CB3 19 0000000000000300 0
03290D33 1A FE00000000000001 0
00708013 00 000000000000000C 0
00000DB3 1B 0000000000000000 0
0210C0B3 01 0000000000000000 1
0010919B 03 0000000000000000 1
00308E33 1C 0000000000000007 0
